// File: cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Address split into tag, index and offset
`define CACHE_TAG_W     21
`define CACHE_INDEX_W   6
`define CACHE_OFFSET_W  5

// Two ways of 64 sets, 32-byte lines
`define CACHE_SETS      64
`define CACHE_LINE_W    256
`define CACHE_WORD_W    64

// Memory line bus fields
`define MEM_ADDR_W      32
`define MEM_TYPE_W      6
`define MEM_STRB_W      16

// Type code of a whole-line transfer
`define MEM_TYPE_LINE   31

`endif

// File: cache_pkg.sv
`include "cache_consts.svh"

package cache_pkg;

    typedef enum logic [3:0] {
        IDLE    = 4'd0,
        LOOKUP  = 4'd1,
        MISS    = 4'd2,
        REPLACE = 4'd3,
        REFILL  = 4'd4,
        WRITE   = 4'd5
    } cache_state_e;

    // One entry per way and set
    typedef struct packed {
        logic                    dirty;
        logic                    valid;
        logic [`CACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
    } cache_addr_fields_t;

    // Same address word, raw or split into fields
    typedef union packed {
        logic [`MEM_ADDR_W-1:0] raw;
        cache_addr_fields_t     f;
    } cache_addr_u;

endpackage

// File: cache_if.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

interface tag_port_if;
    logic [`CACHE_INDEX_W-1:0] index;
    logic [`CACHE_TAG_W-1:0]   wr_tag;
    logic                      en;
    logic                      write;
    logic                      set_valid;
    logic                      set_dirty;
    logic                      wr_way0;
    logic                      wr_way1;
    cache_pkg::tag_entry_t     entry0;
    cache_pkg::tag_entry_t     entry1;
    logic                      hit0;
    logic                      hit1;

    modport ctrl (
        output index, wr_tag, en, write, set_valid, set_dirty, wr_way0, wr_way1,
        input  entry0, entry1, hit0, hit1
    );
    modport store (
        input  index, wr_tag, en, write, set_valid, set_dirty, wr_way0, wr_way1,
        output entry0, entry1, hit0, hit1
    );
endinterface

interface data_port_if;
    logic [`CACHE_INDEX_W-1:0]  index;
    logic                       en;
    logic                       we;
    logic                       way;
    logic [`CACHE_LINE_W-1:0]   wdata;
    logic [`CACHE_LINE_W/8-1:0] byte_mask;
    logic [`CACHE_LINE_W-1:0]   line0;
    logic [`CACHE_LINE_W-1:0]   line1;

    modport ctrl (output index, en, we, way, wdata, byte_mask, input line0, line1);
    modport store (input index, en, we, way, wdata, byte_mask, output line0, line1);
endinterface

// File: line_merge.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module line_merge (
    input  logic [`CACHE_OFFSET_W-1:0] offset,
    input  logic [1:0]                 len,
    input  logic [`CACHE_LINE_W-1:0]   line,
    input  logic [`CACHE_WORD_W-1:0]   wdata,
    output logic [`CACHE_WORD_W-1:0]   rword,
    output logic [`CACHE_LINE_W-1:0]   merged,
    output logic [`CACHE_LINE_W/8-1:0] byte_mask
);

    localparam int LINE_BYTES = `CACHE_LINE_W / 8;
    localparam int WORD_BYTES = `CACHE_WORD_W / 8;

    logic [`CACHE_OFFSET_W+2:0] bit_shift;
    logic [`CACHE_LINE_W-1:0]   line_shifted;
    logic [`CACHE_LINE_W-1:0]   wdata_placed;
    logic [WORD_BYTES-1:0]      len_mask;

    assign bit_shift = {offset, 3'b000};

    // Bytes past the line end shift in as zero
    assign line_shifted = line >> bit_shift;
    assign rword        = line_shifted[`CACHE_WORD_W-1:0];

    // 1, 2, 4 or 8 bytes
    always_comb begin
        case (len)
            2'd0:    len_mask = 8'h01;
            2'd1:    len_mask = 8'h03;
            2'd2:    len_mask = 8'h0f;
            default: len_mask = 8'hff;
        endcase
    end

    // Mask bits shifted beyond byte 31 drop off
    assign byte_mask = {{(LINE_BYTES-WORD_BYTES){1'b0}}, len_mask} << offset;

    assign wdata_placed = {{(`CACHE_LINE_W-`CACHE_WORD_W){1'b0}}, wdata} << bit_shift;

    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            merged[b*8 +: 8] = byte_mask[b] ? wdata_placed[b*8 +: 8] : line[b*8 +: 8];
        end
    end

endmodule

// File: tag_store.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module tag_store (
    input  logic      clk,
    input  logic      rst_n,
    tag_port_if.store tag
);

    cache_pkg::tag_entry_t ways [2][`CACHE_SETS];
    cache_pkg::tag_entry_t entry0_q;
    cache_pkg::tag_entry_t entry1_q;
    logic [1:0]            way_sel;

    assign way_sel = {tag.wr_way1, tag.wr_way0};

    ////////////////////////////////////////////////////////////////////////////
    // Entry array with a one-cycle read
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < `CACHE_SETS; s++) begin
                    ways[w][s] <= '0;
                end
            end
            entry0_q <= '0;
            entry1_q <= '0;
        end else if (tag.en) begin
            entry0_q <= ways[0][tag.index];
            entry1_q <= ways[1][tag.index];
            for (int w = 0; w < 2; w++) begin
                if (way_sel[w]) begin
                    // Full write on refill, dirty-only update on a write hit
                    if (tag.write) begin
                        ways[w][tag.index] <= {tag.set_dirty, tag.set_valid, tag.wr_tag};
                    end else if (tag.set_dirty) begin
                        ways[w][tag.index].dirty <= 1'b1;
                    end
                end
            end
        end
    end

    assign tag.entry0 = entry0_q;
    assign tag.entry1 = entry1_q;

    // Compare against the tag of the request under lookup
    assign tag.hit0 = entry0_q.valid && (entry0_q.tag == tag.wr_tag);
    assign tag.hit1 = entry1_q.valid && (entry1_q.tag == tag.wr_tag);

endmodule

// File: data_store.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module data_store (
    input  logic       clk,
    data_port_if.store data
);

    logic [`CACHE_LINE_W-1:0] ways [2][`CACHE_SETS];
    logic [`CACHE_LINE_W-1:0] line0_q;
    logic [`CACHE_LINE_W-1:0] line1_q;

    // Byte-masked write to one way, or read of both
    always_ff @(posedge clk) begin
        if (data.en) begin
            if (data.we) begin
                for (int b = 0; b < `CACHE_LINE_W/8; b++) begin
                    if (data.byte_mask[b]) begin
                        ways[data.way][data.index][b*8 +: 8] <= data.wdata[b*8 +: 8];
                    end
                end
            end else begin
                line0_q <= ways[0][data.index];
                line1_q <= ways[1][data.index];
            end
        end
    end

    assign data.line0 = line0_q;
    assign data.line1 = line1_q;

endmodule

// File: cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`MEM_ADDR_W-1:0]   addr,
    input  logic [`CACHE_WORD_W-1:0] data_in,
    input  logic [1:0]               len,
    input  logic                     write,
    input  logic                     valid_in,
    output logic                     addr_ok,
    output logic                     data_ok,
    output logic [`CACHE_WORD_W-1:0] data_out,
    output logic                     r_req,
    output logic [`MEM_TYPE_W-1:0]   r_type,
    output logic [`MEM_ADDR_W-1:0]   r_addr,
    input  logic                     r_rdy,
    input  logic [`CACHE_LINE_W-1:0] re_data,
    input  logic                     re_valid,
    output logic                     w_req,
    output logic [`MEM_TYPE_W-1:0]   w_type,
    output logic [`MEM_ADDR_W-1:0]   w_addr,
    output logic [`CACHE_LINE_W-1:0] w_data,
    output logic [`MEM_STRB_W-1:0]   w_strb,
    input  logic                     w_rdy,
    tag_port_if.ctrl                 tag,
    data_port_if.ctrl                data
);

    cache_pkg::cache_state_e    state_q;
    cache_pkg::cache_state_e    state_d;
    cache_pkg::cache_addr_u     in_addr;
    cache_pkg::cache_addr_u     req_q;
    cache_pkg::cache_addr_u     victim_addr;
    cache_pkg::cache_addr_u     fetch_addr;
    logic [`CACHE_WORD_W-1:0]   data_q;
    logic [1:0]                 len_q;
    logic                       write_q;
    logic                       repl_q;
    logic                       hit_way_q;
    cache_pkg::tag_entry_t      entry0_q;
    cache_pkg::tag_entry_t      entry1_q;
    cache_pkg::tag_entry_t      victim_entry;
    logic [`CACHE_LINE_W-1:0]   line0_q;
    logic [`CACHE_LINE_W-1:0]   line1_q;
    logic [`CACHE_LINE_W-1:0]   victim_line;
    logic [`CACHE_LINE_W-1:0]   merge_src;
    logic [`CACHE_LINE_W-1:0]   merged;
    logic [`CACHE_LINE_W/8-1:0] merge_mask;
    logic                       hit;
    logic                       accept;
    logic                       refill_fire;
    logic                       in_write;

    assign in_addr.raw = addr;
    assign hit         = tag.hit0 | tag.hit1;
    assign in_write    = (state_q == cache_pkg::WRITE);
    assign refill_fire = (state_q == cache_pkg::REFILL) && re_valid;

    // A read hit frees the pipeline for the next request
    assign addr_ok = (state_q == cache_pkg::IDLE) ||
                     ((state_q == cache_pkg::LOOKUP) && hit && !write_q);
    assign accept  = valid_in && addr_ok;
    assign data_ok = !write_q && (((state_q == cache_pkg::LOOKUP) && hit) || refill_fire);

    ////////////////////////////////////////////////////////////////////////////
    // State and replacement bit
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= cache_pkg::IDLE;
            repl_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == cache_pkg::LOOKUP) begin
                repl_q <= ~repl_q;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_pkg::IDLE:    state_d = valid_in ? cache_pkg::LOOKUP : cache_pkg::IDLE;
            cache_pkg::LOOKUP: begin
                if (!hit) begin
                    state_d = cache_pkg::MISS;
                end else if (write_q) begin
                    state_d = cache_pkg::WRITE;
                end else if (valid_in) begin
                    state_d = cache_pkg::LOOKUP;
                end else begin
                    state_d = cache_pkg::IDLE;
                end
            end
            // Clean victim skips the write-back
            cache_pkg::MISS: begin
                if (!victim_entry.dirty || w_rdy) begin
                    state_d = cache_pkg::REPLACE;
                end
            end
            cache_pkg::REPLACE: state_d = r_rdy ? cache_pkg::REFILL : cache_pkg::REPLACE;
            cache_pkg::REFILL:  state_d = re_valid ? cache_pkg::IDLE : cache_pkg::REFILL;
            default:            state_d = cache_pkg::IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request register and lookup snapshot
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q   <= in_addr;
            data_q  <= data_in;
            len_q   <= len;
            write_q <= write;
        end
        if (state_q == cache_pkg::LOOKUP) begin
            hit_way_q <= tag.hit1;
            entry0_q  <= tag.entry0;
            entry1_q  <= tag.entry1;
            line0_q   <= data.line0;
            line1_q   <= data.line1;
        end
    end

    assign victim_entry = repl_q ? entry1_q : entry0_q;
    assign victim_line  = repl_q ? line1_q : line0_q;

    always_comb begin
        victim_addr.f.tag    = victim_entry.tag;
        victim_addr.f.index  = req_q.f.index;
        victim_addr.f.offset = '0;
        fetch_addr.f.tag     = req_q.f.tag;
        fetch_addr.f.index   = req_q.f.index;
        fetch_addr.f.offset  = '0;
    end

    // Live line on a hit, latched line for a write, bus line on refill
    always_comb begin
        if (state_q == cache_pkg::LOOKUP) begin
            merge_src = tag.hit1 ? data.line1 : data.line0;
        end else if (in_write) begin
            merge_src = hit_way_q ? line1_q : line0_q;
        end else begin
            merge_src = re_data;
        end
    end

    line_merge merge_i (
        .offset    (req_q.f.offset),
        .len       (len_q),
        .line      (merge_src),
        .wdata     (data_q),
        .rword     (data_out),
        .merged    (merged),
        .byte_mask (merge_mask)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Store ports
    ////////////////////////////////////////////////////////////////////////////
    assign tag.index     = accept ? in_addr.f.index : req_q.f.index;
    assign tag.wr_tag    = req_q.f.tag;
    assign tag.en        = accept || refill_fire || in_write;
    assign tag.write     = refill_fire;
    assign tag.set_valid = refill_fire;
    assign tag.set_dirty = (refill_fire && write_q) || in_write;
    assign tag.wr_way0   = in_write ? !hit_way_q : !repl_q;
    assign tag.wr_way1   = in_write ? hit_way_q : repl_q;

    assign data.index     = tag.index;
    assign data.en        = tag.en;
    assign data.we        = refill_fire || in_write;
    assign data.way       = in_write ? hit_way_q : repl_q;
    assign data.wdata     = write_q ? merged : re_data;
    assign data.byte_mask = in_write ? merge_mask : '1;

    // Write-back in MISS and line fetch in REPLACE
    assign w_req  = (state_q == cache_pkg::MISS) && victim_entry.dirty;
    assign w_type = `MEM_TYPE_W'(`MEM_TYPE_LINE);
    assign w_addr = victim_addr.raw;
    assign w_data = victim_line;
    assign w_strb = '1;
    assign r_req  = (state_q == cache_pkg::REPLACE);
    assign r_type = `MEM_TYPE_W'(`MEM_TYPE_LINE);
    assign r_addr = fetch_addr.raw;

endmodule

// File: cache_top.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`MEM_ADDR_W-1:0]   addr,
    input  logic [`CACHE_WORD_W-1:0] data_in,
    input  logic [1:0]               len,
    input  logic                     write,
    input  logic                     valid_in,
    output logic                     addr_ok,
    output logic                     data_ok,
    output logic [`CACHE_WORD_W-1:0] data_out,
    output logic                     r_req,
    output logic [`MEM_TYPE_W-1:0]   r_type,
    output logic [`MEM_ADDR_W-1:0]   r_addr,
    input  logic                     r_rdy,
    input  logic [`CACHE_LINE_W-1:0] re_data,
    input  logic                     re_valid,
    output logic                     w_req,
    output logic [`MEM_TYPE_W-1:0]   w_type,
    output logic [`MEM_ADDR_W-1:0]   w_addr,
    output logic [`CACHE_LINE_W-1:0] w_data,
    output logic [`MEM_STRB_W-1:0]   w_strb,
    input  logic                     w_rdy
);

    tag_port_if  tag_bus ();
    data_port_if data_bus ();

    // Processor and memory ports pass straight to the controller
    cache_ctrl ctrl_i (
        .*,
        .tag  (tag_bus),
        .data (data_bus)
    );

    tag_store tags_i (
        .clk   (clk),
        .rst_n (rst_n),
        .tag   (tag_bus)
    );

    data_store lines_i (
        .clk  (clk),
        .data (data_bus)
    );

endmodule

// File: tb_cache_top.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_cache_top;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 10;
    localparam int SEED           = 68163;
    localparam int NUM_RANDOM     = 400;
    localparam int NUM_SWEEP      = 8 * 4 * 4;
    localparam int NUM_REQ        = 4 + NUM_RANDOM + NUM_SWEEP;
    localparam int CYCLES_PER_REQ = 40;
    localparam int MEM_BYTES      = 16384;

    logic                     clk;
    logic                     rst_n;
    logic [`MEM_ADDR_W-1:0]   addr;
    logic [`CACHE_WORD_W-1:0] data_in;
    logic [1:0]               len;
    logic                     write;
    logic                     valid_in;
    logic                     addr_ok;
    logic                     data_ok;
    logic [`CACHE_WORD_W-1:0] data_out;
    logic                     r_req;
    logic [`MEM_TYPE_W-1:0]   r_type;
    logic [`MEM_ADDR_W-1:0]   r_addr;
    logic                     r_rdy;
    logic [`CACHE_LINE_W-1:0] re_data;
    logic                     re_valid;
    logic                     w_req;
    logic [`MEM_TYPE_W-1:0]   w_type;
    logic [`MEM_ADDR_W-1:0]   w_addr;
    logic [`CACHE_LINE_W-1:0] w_data;
    logic [`MEM_STRB_W-1:0]   w_strb;
    logic                     w_rdy;

    // Main memory behind the bus, and the expected view of every byte
    logic [7:0]               main_mem [MEM_BYTES];
    logic [7:0]               shadow [MEM_BYTES];
    logic [63:0]              pending_q [$];
    logic [63:0]              exp_word = '0;
    logic [`CACHE_LINE_W-1:0] wb_expect = '0;
    logic                     stray_data_ok = 1'b0;
    logic                     idle_phase;
    logic                     b2b_expect;
    int                       err_count = 0;
    int                       reads_done = 0;
    int                       writes_done = 0;
    int                       wb_count = 0;

    cache_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Indices 0, 21, 42 and 63
    function automatic logic [31:0] make_addr(input int unsigned tag_n, input int unsigned idx_n,
                                              input int unsigned off);
        return 32'((tag_n << 11) | ((idx_n * 21) << 5) | off);
    endfunction

    function automatic logic [`CACHE_LINE_W-1:0] line_of(input logic from_shadow,
                                                         input logic [31:0] a);
        logic [`CACHE_LINE_W-1:0] line;
        int                       base;
        base = int'({a[13:5], 5'b00000});
        for (int b = 0; b < 32; b++) begin
            line[b*8 +: 8] = from_shadow ? shadow[base + b] : main_mem[base + b];
        end
        return line;
    endfunction

    // Eight bytes from the offset on, zero past the end of the line
    function automatic logic [63:0] expect_read(input logic [31:0] a);
        logic [63:0] word;
        int          base;
        int          off;
        word = '0;
        base = int'({a[13:5], 5'b00000});
        off  = int'(a[4:0]);
        for (int i = 0; i < 8; i++) begin
            if (off + i < 32) begin
                word[i*8 +: 8] = shadow[base + off + i];
            end
        end
        return word;
    endfunction

    task automatic apply_write(input logic [31:0] a, input logic [63:0] d, input logic [1:0] l);
        int base;
        base = int'(a[13:0]);
        for (int i = 0; i < (1 << l); i++) begin
            shadow[base + i] = d[i*8 +: 8];
        end
    endtask

    task automatic send_request(input logic [31:0] a, input logic [63:0] d, input logic [1:0] l,
                                input logic wr);
        valid_in = 1'b1;
        addr     = a;
        data_in  = d;
        len      = l;
        write    = wr;
        @(negedge clk);
        while (!addr_ok) @(negedge clk);
        @(posedge clk);
        #1;
        valid_in = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory model with random ready and refill delays
    ////////////////////////////////////////////////////////////////////////////
    initial begin : memory_model
        logic        w_armed;
        logic        r_armed;
        logic        re_armed;
        int unsigned w_wait;
        int unsigned r_wait;
        int unsigned re_wait;
        logic [31:0] fetch_base;
        r_rdy      = 1'b0;
        w_rdy      = 1'b0;
        re_valid   = 1'b0;
        re_data    = '0;
        w_armed    = 1'b0;
        r_armed    = 1'b0;
        re_armed   = 1'b0;
        w_wait     = 0;
        r_wait     = 0;
        re_wait    = 0;
        fetch_base = '0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            main_mem[a] = 8'(a ^ (a >> 5) * 29 ^ (a >> 8) * 3);
            shadow[a]   = main_mem[a];
        end
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (w_req && w_rdy) begin
                    for (int b = 0; b < 32; b++) begin
                        main_mem[int'({w_addr[13:5], 5'b00000}) + b] = w_data[b*8 +: 8];
                    end
                    wb_count++;
                    w_armed = 1'b0;
                end else if (w_req && !w_armed) begin
                    w_armed = 1'b1;
                    w_wait  = $urandom_range(0, 5);
                end else if (w_armed && w_wait != 0) begin
                    w_wait--;
                end
                // Refill return before a new fetch is taken
                if (re_valid) begin
                    re_armed = 1'b0;
                end else if (re_armed && re_wait != 0) begin
                    re_wait--;
                end
                if (r_req && r_rdy) begin
                    r_armed    = 1'b0;
                    re_armed   = 1'b1;
                    re_wait    = $urandom_range(0, 5);
                    fetch_base = {r_addr[31:5], 5'b00000};
                end else if (r_req && !r_armed) begin
                    r_armed = 1'b1;
                    r_wait  = $urandom_range(0, 5);
                end else if (r_armed && r_wait != 0) begin
                    r_wait--;
                end
            end
            @(posedge clk);
            #1;
            w_rdy    = w_armed && (w_wait == 0);
            r_rdy    = r_armed && (r_wait == 0);
            re_valid = re_armed && (re_wait == 0);
            if (re_valid) begin
                re_data = line_of(1'b0, fetch_base);
            end
        end
    end

    // Shadow update and expected read data in acceptance order
    always @(negedge clk) begin : monitor
        if (rst_n) begin
            stray_data_ok = 1'b0;
            if (data_ok) begin
                if (pending_q.size() == 0) begin
                    stray_data_ok = 1'b1;
                end else begin
                    exp_word = pending_q.pop_front();
                    reads_done++;
                end
            end
            if (valid_in && addr_ok) begin
                if (write) begin
                    apply_write(addr, data_in, len);
                    writes_done++;
                end else begin
                    pending_q.push_back(expect_read(addr));
                end
            end
            wb_expect = line_of(1'b1, w_addr);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    assert property (@(posedge clk) disable iff (!rst_n)
        idle_phase |-> (addr_ok && !r_req && !w_req && !data_ok))
        else begin
            err_count++;
            $display("[FAIL] %0t ns: cache not idle after reset", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) data_ok |-> !stray_data_ok)
        else begin
            err_count++;
            $display("data_ok at %0t ns with no read pending", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (data_ok && !stray_data_ok) |-> (data_out == exp_word))
        else begin
            err_count++;
            $display("[FAIL] %0t ns: data_out %h, expected %h", $time, data_out, exp_word);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (w_req && w_rdy) |-> (w_addr[4:0] == 5'd0 && w_type == `MEM_TYPE_W'(`MEM_TYPE_LINE) &&
                              w_strb == '1))
        else begin
            err_count++;
            $display("[FAIL] %0t ns: write-back fields addr %h type %0d strb %h",
                     $time, w_addr, w_type, w_strb);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (w_req && w_rdy) |-> (w_data == wb_expect))
        else begin
            err_count++;
            $display("[FAIL] %0t ns: write-back data of line %h differs", $time, w_addr);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        r_req |-> (r_addr[4:0] == 5'd0 && r_type == `MEM_TYPE_W'(`MEM_TYPE_LINE) && !w_req))
        else begin
            err_count++;
            $display("[FAIL] %0t ns: line fetch addr %h type %0d w_req %b",
                     $time, r_addr, r_type, w_req);
        end

    // Read hit must take the next request at once
    assert property (@(posedge clk) disable iff (!rst_n) b2b_expect |-> addr_ok)
        else begin
            err_count++;
            $display("[FAIL] %0t ns: addr_ok low behind a read hit", $time);
        end

    initial begin : watchdog
        #(CLK_PERIOD * (RESET_CYCLES + NUM_REQ * CYCLES_PER_REQ));
        $display("Timeout: run did not finish within %0d cycles",
                 RESET_CYCLES + NUM_REQ * CYCLES_PER_REQ);
        $display("reads=%0d writes=%0d write-backs=%0d errors=%0d",
                 reads_done, writes_done, wb_count, err_count);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : stimulus
        int unsigned tag_n;
        int unsigned idx_n;
        int unsigned l;
        int unsigned off;
        logic [31:0] a0;
        void'($urandom(SEED));
        rst_n      = 1'b0;
        addr       = '0;
        data_in    = '0;
        len        = '0;
        write      = 1'b0;
        valid_in   = 1'b0;
        idle_phase = 1'b0;
        b2b_expect = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n      = 1'b1;
        idle_phase = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        idle_phase = 1'b0;

        // Cold miss, then pipelined hits on one line
        a0 = make_addr(5, 2, 0);
        send_request(a0, 64'd0, 2'd3, 1'b0);
        send_request(a0, 64'd0, 2'd3, 1'b0);
        b2b_expect = 1'b1;
        send_request(a0 + 32'd8, 64'd0, 2'd3, 1'b0);
        send_request(a0 + 32'd24, 64'd0, 2'd3, 1'b0);
        b2b_expect = 1'b0;

        for (int n = 0; n < NUM_RANDOM; n++) begin
            tag_n = $urandom_range(0, 7);
            idx_n = $urandom_range(0, 3);
            l     = $urandom_range(0, 3);
            off   = $urandom_range(0, 31) & ~((1 << l) - 1);
            send_request(make_addr(tag_n, idx_n, off), {$urandom, $urandom}, 2'(l),
                         $urandom_range(0, 2) == 0);
            if ($urandom_range(0, 3) == 0) begin
                @(posedge clk);
                #1;
            end
        end

        // Read back every word that the traffic could reach
        for (int t = 0; t < 8; t++) begin
            for (int i = 0; i < 4; i++) begin
                for (int w = 0; w < 4; w++) begin
                    send_request(make_addr(t, i, w * 8), 64'd0, 2'd3, 1'b0);
                end
            end
        end

        while (pending_q.size() != 0) @(negedge clk);
        repeat (5) @(posedge clk);
        $display("reads=%0d writes=%0d write-backs=%0d errors=%0d",
                 reads_done, writes_done, wb_count, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
cache_pkg.sv
cache_if.sv
line_merge.sv
tag_store.sv
data_store.sv
cache_ctrl.sv
cache_top.sv
tb_cache_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f compile.f --top-module tb_cache_top \
    -Mdir obj_dir -o sim_cache > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
    exit 0
fi
exit 1
